// ==== list.f ====
lcd_pkg.sv
lcd_controller.sv
lcd_cmd_dispatch.sv
lcd_status_collect.sv
lcd_array_top.sv
lcd_array_checker.sv
tb_lcd_array.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and pass only if the testbench reports a pass
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_lcd_array -f list.f -o sim_lcd_array || exit 1
out=$(./obj_dir/sim_lcd_array)
echo "$out"
echo "$out" | grep -qx "Simulation passed" && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tb_lcd_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_lcd_array;

	logic                                       clk;
	logic                                       rst_n;
	logic [6:0]                                 cfg;
	logic                                       host_wr;
	logic [lcd_pkg::idx_bits-1:0]               host_sel;
	logic [9:0]                                 host_word;
	logic [lcd_pkg::num_lcd-1:0]                ready;
	logic                                       reject;
	logic                                       all_init;
	logic [lcd_pkg::num_lcd*lcd_pkg::cnt_w-1:0] xfer_count;
	logic [lcd_pkg::num_lcd-1:0]                e;
	logic [lcd_pkg::num_lcd-1:0]                rs;
	logic [lcd_pkg::num_lcd-1:0]                rw;
	logic [lcd_pkg::num_lcd*8-1:0]              lcd_data;

	// reference model, one entry per display
	int         cyc;                             // cycles since reset release
	int         busy_until [lcd_pkg::num_lcd];   // last busy cycle
	int         x_start [lcd_pkg::num_lcd];      // acceptance cycle, -1 before any
	logic [9:0] pin_word [lcd_pkg::num_lcd];
	bit         slot_full [lcd_pkg::num_lcd];
	logic [9:0] slot_word [lcd_pkg::num_lcd];
	bit         busy_prev [lcd_pkg::num_lcd];
	bit         init_done_m [lcd_pkg::num_lcd];
	int         count_m [lcd_pkg::num_lcd];      // as the collector shows it
	int         launches [lcd_pkg::num_lcd];
	bit         reject_m;
	int         accepted;                        // host words taken into a slot
	int         errors;
	int         checks;
	logic [31:0] rng_state;

	lcd_array_top dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg        (cfg),
		.host_wr    (host_wr),
		.host_sel   (host_sel),
		.host_word  (host_word),
		.ready      (ready),
		.reject     (reject),
		.all_init   (all_init),
		.xfer_count (xfer_count),
		.e          (e),
		.rs         (rs),
		.rw         (rw),
		.lcd_data   (lcd_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// init command window, start and length in microseconds
	function automatic bit in_cmd_window(input int t, input int start_us);
		return (t >= start_us * lcd_pkg::clk_per_us) &&
			(t < (start_us + 10) * lcd_pkg::clk_per_us);
	endfunction

	// {e, rs, rw, data} expected in the current cycle
	function automatic logic [10:0] expected_pins(input int d);
		int          t;
		int          age;
		logic [10:0] p;
		p = '0;
		t = cyc - lcd_pkg::powerup_cycles;
		if (t >= 0 && t < lcd_pkg::init_cycles) begin
			if (in_cmd_window(t, 0))
				p = {3'b100, 4'b0011, cfg[6], cfg[5], 2'b00};
			else if (in_cmd_window(t, 60))
				p = {3'b100, 5'b00001, cfg[4:2]};
			else if (in_cmd_window(t, 120))
				p = {3'b100, 8'h01};
			else if (in_cmd_window(t, 330))
				p = {3'b100, 6'b000001, cfg[1:0]};
		end else if (x_start[d] >= 0) begin
			age = cyc - x_start[d]; // acceptance cycle is age 0
			if (age >= 1 && age <= lcd_pkg::xfer_cycles) begin
				p[9:0] = pin_word[d];
				p[10] = (age >= lcd_pkg::e_rise) && (age < lcd_pkg::e_fall);
			end
		end
		return p;
	endfunction

	function automatic bit model_quiet();
		for (int d = 0; d < lcd_pkg::num_lcd; d++) begin
			if (slot_full[d] || busy_prev[d] || cyc <= busy_until[d])
				return 1'b0;
		end
		return 1'b1;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %s at cycle %0d: expected 'h%0h, actual 'h%0h",
				name, cyc, expected, actual);
		end
	endtask

	task automatic reset_model();
		cyc = 0;
		reject_m = 1'b0;
		accepted = 0;
		for (int d = 0; d < lcd_pkg::num_lcd; d++) begin
			busy_until[d] = lcd_pkg::powerup_cycles + lcd_pkg::init_cycles - 1;
			x_start[d] = -1;
			pin_word[d] = '0;
			slot_full[d] = 1'b0;
			slot_word[d] = '0;
			busy_prev[d] = 1'b1; // busy out of reset
			init_done_m[d] = 1'b0;
			count_m[d] = 0;
			launches[d] = 0;
		end
	endtask

	// one clock edge, from the inputs held in the ending cycle
	task automatic advance_model();
		bit b;
		bit full_before;
		for (int d = 0; d < lcd_pkg::num_lcd; d++) begin
			b = (cyc <= busy_until[d]);
			full_before = slot_full[d];
			if (full_before && !b) begin // launch
				x_start[d] = cyc;
				busy_until[d] = cyc + lcd_pkg::xfer_cycles;
				pin_word[d] = slot_word[d];
				slot_full[d] = 1'b0;
				launches[d]++;
			end
			if (host_wr && int'(host_sel) == d) begin
				if (full_before) begin
					reject_m = 1'b1; // word dropped
				end else begin
					slot_full[d] = 1'b1;
					slot_word[d] = host_word;
					accepted++;
				end
			end
			if (busy_prev[d] && !b) begin
				if (init_done_m[d])
					count_m[d]++;
				else
					init_done_m[d] = 1'b1;
			end
			busy_prev[d] = b;
		end
		cyc++;
	endtask

	task automatic compare_outputs();
		logic [10:0] act;
		bit          rdy;
		bit          all_m;
		all_m = 1'b1;
		for (int d = 0; d < lcd_pkg::num_lcd; d++) begin
			act = {e[d], rs[d], rw[d], lcd_data[d*8 +: 8]};
			check_value($sformatf("pins of lcd%0d", d), 32'(expected_pins(d)), 32'(act));
			rdy = (cyc > busy_until[d]) && !slot_full[d];
			check_value($sformatf("ready of lcd%0d", d), 32'(rdy), 32'(ready[d]));
			check_value($sformatf("xfer_count of lcd%0d", d), count_m[d],
				32'(xfer_count[d*lcd_pkg::cnt_w +: lcd_pkg::cnt_w]));
			all_m = all_m && init_done_m[d];
		end
		check_value("all_init", 32'(all_m), 32'(all_init));
		check_value("reject", 32'(reject_m), 32'(reject));
	endtask

	task automatic run_cycle(input bit wr, input logic [lcd_pkg::idx_bits-1:0] sel,
			input logic [9:0] word);
		@(posedge clk);
		advance_model();
		#1;
		host_wr = wr;
		host_sel = sel;
		host_word = word;
		@(negedge clk);
		compare_outputs();
	endtask

	initial begin
		logic [31:0] r;
		rst_n = 1'b0;
		host_wr = 1'b0;
		host_sel = '0;
		host_word = '0;
		errors = 0;
		checks = 0;
		rng_state = 32'd84164;
		r = next_random();
		cfg = r[6:0]; // held for the whole run
		reset_model();
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;
		@(negedge clk);
		compare_outputs();

		// no host traffic until the bank reports init done
		while (all_init !== 1'b1) begin
			run_cycle(1'b0, '0, '0);
		end
		check_value("all_init rise cycle",
			lcd_pkg::powerup_cycles + lcd_pkg::init_cycles + 1, cyc);

		// about one write in eight cycles, to any display
		while (accepted < 200) begin
			r = next_random();
			run_cycle(r[2:0] == 3'd0, r[8 +: lcd_pkg::idx_bits], r[21:12]);
		end

		while (!model_quiet()) begin
			run_cycle(1'b0, '0, '0);
		end
		for (int d = 0; d < lcd_pkg::num_lcd; d++) begin
			check_value($sformatf("launched transfers of lcd%0d", d), launches[d],
				32'(xfer_count[d*lcd_pkg::cnt_w +: lcd_pkg::cnt_w]));
		end
		check_value("reject after random run", 1, 32'(reject));

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// init time plus 200 back-to-back transfers, doubled
	initial begin : watchdog
		int limit_cycles;
		limit_cycles = 2 * (lcd_pkg::powerup_cycles + lcd_pkg::init_cycles +
			200 * (lcd_pkg::xfer_cycles + 2));
		#(limit_cycles * 8);
		$display("timeout: run did not finish within %0d cycles", limit_cycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== lcd_array_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module lcd_array_checker (
	input wire       clk,
	input wire       rst_n,
	input wire [1:0] phase,
	input wire       lcd_enable,
	input wire       e,
	input wire       rw,
	input wire       busy
);

	// strobe only inside a busy period
	e_only_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
		e |-> busy)
		else $error("e high while the controller is not busy");

	idle_enable_sets_busy: assert property (@(posedge clk) disable iff (!rst_n)
		(lcd_enable && phase == lcd_pkg::ph_idle) |=> busy)
		else $error("accepted lcd_enable did not raise busy");

	// power-up wait and init sequence are write only
	no_read_during_init: assert property (@(posedge clk) disable iff (!rst_n)
		(phase == lcd_pkg::ph_power || phase == lcd_pkg::ph_init) |-> !rw)
		else $error("rw high before initialization finished");

endmodule

bind lcd_controller lcd_array_checker u_checker (
	.clk        (clk),
	.rst_n      (rst_n),
	.phase      (phase),
	.lcd_enable (lcd_enable),
	.e          (e),
	.rw         (rw),
	.busy       (busy)
);

`default_nettype wire

// ==== lcd_array_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module lcd_array_top (
	input  wire                                        clk,
	input  wire                                        rst_n,
	input  wire  [6:0]                                 cfg,
	input  wire                                        host_wr,
	input  wire  [lcd_pkg::idx_bits-1:0]               host_sel,
	input  wire  [9:0]                                 host_word,
	output logic [lcd_pkg::num_lcd-1:0]                ready,
	output logic                                       reject,
	output logic                                       all_init,
	output logic [lcd_pkg::num_lcd*lcd_pkg::cnt_w-1:0] xfer_count, // display 0 lowest
	output logic [lcd_pkg::num_lcd-1:0]                e,
	output logic [lcd_pkg::num_lcd-1:0]                rs,
	output logic [lcd_pkg::num_lcd-1:0]                rw,
	output logic [lcd_pkg::num_lcd*8-1:0]              lcd_data    // display 0 lowest
);

	logic [lcd_pkg::num_lcd-1:0]      lcd_enable;
	logic [lcd_pkg::num_lcd-1:0][9:0] bus;
	logic [lcd_pkg::num_lcd-1:0]      busy;

	lcd_cmd_dispatch u_dispatch (
		.clk        (clk),
		.rst_n      (rst_n),
		.host_wr    (host_wr),
		.host_sel   (host_sel),
		.host_word  (host_word),
		.busy       (busy),
		.lcd_enable (lcd_enable),
		.bus        (bus),
		.ready      (ready),
		.reject     (reject)
	);

	for (genvar g = 0; g < lcd_pkg::num_lcd; g++) begin : gen_lcd
		lcd_controller u_ctrl (
			.clk        (clk),
			.rst_n      (rst_n),
			.cfg        (cfg),
			.lcd_enable (lcd_enable[g]),
			.bus        (bus[g]),
			.e          (e[g]),
			.rs         (rs[g]),
			.rw         (rw[g]),
			.lcd_data   (lcd_data[g*8 +: 8]),
			.busy       (busy[g])
		);
	end

	lcd_status_collect u_status (
		.clk        (clk),
		.rst_n      (rst_n),
		.busy       (busy),
		.all_init   (all_init),
		.xfer_count (xfer_count)
	);

endmodule

`default_nettype wire

// ==== lcd_status_collect.sv ====
`timescale 1ns/100ps
`default_nettype none

module lcd_status_collect (
	input  wire                                          clk,
	input  wire                                          rst_n,
	input  wire  [lcd_pkg::num_lcd-1:0]                  busy,
	output logic                                         all_init,
	output logic [lcd_pkg::num_lcd-1:0][lcd_pkg::cnt_w-1:0] xfer_count
);

	logic [lcd_pkg::num_lcd-1:0] busy_d;    // busy one cycle late
	logic [lcd_pkg::num_lcd-1:0] busy_fall;
	logic [lcd_pkg::num_lcd-1:0] init_done; // first fall seen

	assign busy_fall = busy_d & ~busy;
	assign all_init = &init_done;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_d <= '1; // controllers come out of reset busy
			init_done <= '0;
			xfer_count <= '0;
		end else begin
			busy_d <= busy;
			for (int i = 0; i < lcd_pkg::num_lcd; i++) begin
				if (busy_fall[i]) begin
					if (init_done[i]) begin
						xfer_count[i] <= xfer_count[i] + 1'b1; // transfer done
					end else begin
						init_done[i] <= 1'b1; // end of init
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== lcd_cmd_dispatch.sv ====
`timescale 1ns/100ps
`default_nettype none

module lcd_cmd_dispatch (
	input  wire                                    clk,
	input  wire                                    rst_n,
	input  wire                                    host_wr,
	input  wire  [lcd_pkg::idx_bits-1:0]           host_sel,
	input  wire  [9:0]                             host_word,
	input  wire  [lcd_pkg::num_lcd-1:0]            busy,
	output logic [lcd_pkg::num_lcd-1:0]            lcd_enable,
	output logic [lcd_pkg::num_lcd-1:0][9:0]       bus,
	output logic [lcd_pkg::num_lcd-1:0]            ready,
	output logic                                   reject
);

	logic [lcd_pkg::num_lcd-1:0] slot_vld; // pending word held
	logic [lcd_pkg::num_lcd-1:0] wr_hit;   // host write aimed at display

	always_comb begin
		for (int i = 0; i < lcd_pkg::num_lcd; i++) begin
			wr_hit[i] = host_wr && (host_sel == lcd_pkg::idx_bits'(i));
		end
	end

	assign lcd_enable = slot_vld & ~busy; // launch as soon as display idles
	assign ready = ~busy & ~slot_vld;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			slot_vld <= '0;
			reject <= 1'b0;
		end else begin
			for (int i = 0; i < lcd_pkg::num_lcd; i++) begin
				if (wr_hit[i] && !slot_vld[i]) begin
					slot_vld[i] <= 1'b1;
				end else if (lcd_enable[i]) begin
					slot_vld[i] <= 1'b0; // cleared in launch cycle
				end
			end
			if (|(wr_hit & slot_vld)) begin
				reject <= 1'b1; // sticky until reset
			end
		end
	end

	// pending words, only loaded into an empty slot
	always_ff @(posedge clk) begin
		for (int i = 0; i < lcd_pkg::num_lcd; i++) begin
			if (wr_hit[i] && !slot_vld[i]) begin
				bus[i] <= host_word;
			end
		end
	end

endmodule

`default_nettype wire

// ==== lcd_controller.sv ====
`timescale 1ns/100ps
`default_nettype none

module lcd_controller (
	input  wire        clk,
	input  wire        rst_n,
	input  wire  [6:0] cfg,        // lines, font, on, cursor, blink, inc, shift
	input  wire        lcd_enable,
	input  wire  [9:0] bus,        // rs, rw, data
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data,
	output logic       busy
);

	logic [1:0] phase;
	logic [1:0] phase_nxt;
	logic [lcd_pkg::cnt_bits-1:0] cnt;
	logic [lcd_pkg::cnt_bits-1:0] cnt_nxt;

	logic       e_nxt;
	logic       rs_nxt;
	logic       rw_nxt;
	logic [7:0] data_nxt;
	logic       busy_nxt;

	// true while c lies in the init window starting at start
	function automatic logic in_win(input logic [lcd_pkg::cnt_bits-1:0] c, input int start);
		int unsigned cv;
		cv = int'(c);
		return (cv >= start) && (cv < start + lcd_pkg::init_win_len);
	endfunction

	// phase sequencing, one counter shared by all phases
	always_comb begin
		phase_nxt = phase;
		cnt_nxt = cnt + 1'b1;
		case (phase)
			lcd_pkg::ph_power: begin
				if (cnt == lcd_pkg::cnt_bits'(lcd_pkg::powerup_cycles - 1)) begin
					phase_nxt = lcd_pkg::ph_init;
					cnt_nxt = '0;
				end
			end
			lcd_pkg::ph_init: begin
				if (cnt == lcd_pkg::cnt_bits'(lcd_pkg::init_cycles - 1)) begin
					phase_nxt = lcd_pkg::ph_idle;
					cnt_nxt = '0;
				end
			end
			lcd_pkg::ph_idle: begin
				cnt_nxt = '0;
				if (lcd_enable) begin
					phase_nxt = lcd_pkg::ph_xfer;
					cnt_nxt = lcd_pkg::cnt_bits'(1); // offset from acceptance
				end
			end
			default: begin // transfer
				if (cnt == lcd_pkg::cnt_bits'(lcd_pkg::xfer_cycles)) begin
					phase_nxt = lcd_pkg::ph_idle;
					cnt_nxt = '0;
				end
			end
		endcase
	end

	// pin values for the coming cycle, decoded from next phase and count
	always_comb begin
		e_nxt = 1'b0;
		rs_nxt = 1'b0;
		rw_nxt = 1'b0;
		data_nxt = 8'h00;
		busy_nxt = 1'b1;
		case (phase_nxt)
			lcd_pkg::ph_init: begin
				if (in_win(cnt_nxt, lcd_pkg::init_fs_at)) begin
					e_nxt = 1'b1;
					data_nxt = {4'b0011, cfg[6], cfg[5], 2'b00}; // function set
				end else if (in_win(cnt_nxt, lcd_pkg::init_dc_at)) begin
					e_nxt = 1'b1;
					data_nxt = {5'b00001, cfg[4], cfg[3], cfg[2]}; // display control
				end else if (in_win(cnt_nxt, lcd_pkg::init_clr_at)) begin
					e_nxt = 1'b1;
					data_nxt = 8'b0000_0001; // clear
				end else if (in_win(cnt_nxt, lcd_pkg::init_em_at)) begin
					e_nxt = 1'b1;
					data_nxt = {6'b000001, cfg[1], cfg[0]}; // entry mode
				end
			end
			lcd_pkg::ph_idle: begin
				busy_nxt = 1'b0;
			end
			lcd_pkg::ph_xfer: begin
				e_nxt = (cnt_nxt >= lcd_pkg::cnt_bits'(lcd_pkg::e_rise)) &&
					(cnt_nxt < lcd_pkg::cnt_bits'(lcd_pkg::e_fall));
				if (phase == lcd_pkg::ph_idle) begin // accepting now
					rs_nxt = bus[9];
					rw_nxt = bus[8];
					data_nxt = bus[7:0];
				end else begin // hold for whole transfer
					rs_nxt = rs;
					rw_nxt = rw;
					data_nxt = lcd_data;
				end
			end
			default: ; // power-up wait, pins quiet
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= lcd_pkg::ph_power;
			cnt <= '0;
			e <= 1'b0;
			rs <= 1'b0;
			rw <= 1'b0;
			lcd_data <= 8'h00;
			busy <= 1'b1; // busy through power-up
		end else begin
			phase <= phase_nxt;
			cnt <= cnt_nxt;
			e <= e_nxt;
			rs <= rs_nxt;
			rw <= rw_nxt;
			lcd_data <= data_nxt;
			busy <= busy_nxt;
		end
	end

endmodule

`default_nettype wire

// ==== lcd_pkg.sv ====
`default_nettype none

package lcd_pkg;

	localparam int num_lcd = 4;          // displays in the bank
	localparam int clk_per_us = 2;       // kept small for simulation

	// phase lengths in clock cycles
	localparam int powerup_cycles = 500 * clk_per_us;
	localparam int init_cycles = 440 * clk_per_us;
	localparam int xfer_cycles = 50 * clk_per_us;

	// enable-high window of a transfer, counted from acceptance
	localparam int e_rise = 1 * clk_per_us;
	localparam int e_fall = 14 * clk_per_us;

	// init command windows, offsets from end of power-up wait
	localparam int init_win_len = 10 * clk_per_us;
	localparam int init_fs_at = 0 * clk_per_us;    // function set
	localparam int init_dc_at = 60 * clk_per_us;   // display control
	localparam int init_clr_at = 120 * clk_per_us; // clear
	localparam int init_em_at = 330 * clk_per_us;  // entry mode

	// controller phase encoding
	localparam logic [1:0] ph_power = 2'd0;
	localparam logic [1:0] ph_init = 2'd1;
	localparam logic [1:0] ph_idle = 2'd2;
	localparam logic [1:0] ph_xfer = 2'd3;

	// widths
	localparam int cnt_bits = $clog2(powerup_cycles + 1); // longest phase
	localparam int idx_bits = $clog2(num_lcd);
	localparam int cnt_w = 16;

endpackage

`default_nettype wire
